// ==== common/wide_router_cfg.svh ====
// Build-time sizes of the wide router and its bank array.
// Include this header in every file that sizes a port or a loop.
// All sizes are fixed for one build. The bank count must be a power of two.

`ifndef WIDE_ROUTER_CFG_SVH
`define WIDE_ROUTER_CFG_SVH

// number of 32-bit lanes carried by the wide port
`define WR_NB_LANES 4

// number of word-interleaved memory banks
`define WR_NB_BANKS 8

// width of one lane word
`define WR_LANE_DW 32

// word address width inside one bank, i.e. the row
`define WR_BANK_AW 8

// bank select width, log2 of the bank count
`define WR_BANK_SW 3

// byte address of the wide port: row, bank select and byte offset
`define WR_WIDE_AW (`WR_BANK_AW + `WR_BANK_SW + 2)

`endif

// ==== common/wide_router_pkg.sv ====
// Shared types of the wide router.
// Modules refer to these by scoped name (wide_router_pkg::name).
// The sizes come from the cfg header.

`include "wide_router_cfg.svh"

package wide_router_pkg;

  // one lane word, which is also one bank word
  typedef logic [`WR_LANE_DW-1:0] lane_data_t;

  // full wide word, lane 0 in the low bits
  typedef logic [`WR_NB_LANES*`WR_LANE_DW-1:0] wide_data_t;

  // byte enables of one lane
  typedef logic [`WR_LANE_DW/8-1:0] lane_be_t;

  // byte enables of the wide word, lane 0 in the low bits
  typedef logic [`WR_NB_LANES*`WR_LANE_DW/8-1:0] wide_be_t;

  // byte address seen by the wide initiator
  // bits 1:0 byte offset, then bank select, then row
  typedef logic [`WR_WIDE_AW-1:0] wide_addr_t;

  // row address inside one bank
  typedef logic [`WR_BANK_AW-1:0] bank_addr_t;

  // bank index
  // also the rotation offset between lanes and banks
  typedef logic [`WR_BANK_SW-1:0] bank_sel_t;

endpackage

// ==== filelist.f ====
+incdir+common
common/wide_router_pkg.sv
wide_router/wide_router_decode.sv
wide_router/wide_router_reorder.sv
wide_router/wide_router_resp.sv
rtl/wide_router_top.sv
verif/tb_bank_model.sv
verif/tb_wide_router.sv

// ==== rtl/wide_router_top.sv ====
// Shallow router from one wide initiator port to word-interleaved banks.
// Instantiate it between a wide master and the bank array. Banks must
// grant the lanes of one request together and answer one cycle later.

`include "wide_router_cfg.svh"

module wide_router_top (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           clear_i,
  // wide initiator side
  input  logic                                           wide_req_i,
  input  logic                                           wide_wen_i,
  input  wide_router_pkg::wide_addr_t                    wide_add_i,
  input  wide_router_pkg::wide_be_t                      wide_be_i,
  input  wide_router_pkg::wide_data_t                    wide_wdata_i,
  output logic                                           wide_gnt_o,
  output logic                                           wide_rvalid_o,
  output wide_router_pkg::wide_data_t                    wide_rdata_o,
  // bank side, one entry per bank
  output logic [`WR_NB_BANKS-1:0]                        bank_req_o,
  output logic                                           bank_wen_o,
  output wide_router_pkg::bank_addr_t [`WR_NB_BANKS-1:0] bank_add_o,
  output wide_router_pkg::lane_be_t [`WR_NB_BANKS-1:0]   bank_be_o,
  output wide_router_pkg::lane_data_t [`WR_NB_BANKS-1:0] bank_wdata_o,
  input  logic [`WR_NB_BANKS-1:0]                        bank_gnt_i,
  input  logic [`WR_NB_BANKS-1:0]                        bank_rvalid_i,
  input  wide_router_pkg::lane_data_t [`WR_NB_BANKS-1:0] bank_rdata_i
);

  // per-lane routing from decode
  wide_router_pkg::bank_sel_t [`WR_NB_LANES-1:0]  lane_bank;
  wide_router_pkg::bank_addr_t [`WR_NB_LANES-1:0] lane_add;
  logic [`WR_NB_LANES-1:0]                        lane_act;
  wide_router_pkg::bank_sel_t                     offset;
  // transfer strobe toward the response stage
  logic                                           lane0_gnt;

  wide_router_decode i_decode (
    .wide_req_i  ( wide_req_i ),
    .wide_add_i  ( wide_add_i ),
    .lane_bank_o ( lane_bank  ),
    .lane_add_o  ( lane_add   ),
    .lane_act_o  ( lane_act   ),
    .offset_o    ( offset     )
  );

  wide_router_reorder i_reorder (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .lane_bank_i  ( lane_bank    ),
    .lane_add_i   ( lane_add     ),
    .lane_act_i   ( lane_act     ),
    .wide_wen_i   ( wide_wen_i   ),
    .wide_be_i    ( wide_be_i    ),
    .wide_wdata_i ( wide_wdata_i ),
    .bank_gnt_i   ( bank_gnt_i   ),
    .bank_req_o   ( bank_req_o   ),
    .bank_wen_o   ( bank_wen_o   ),
    .bank_add_o   ( bank_add_o   ),
    .bank_be_o    ( bank_be_o    ),
    .bank_wdata_o ( bank_wdata_o ),
    .lane0_gnt_o  ( lane0_gnt    ),
    .wide_gnt_o   ( wide_gnt_o   )
  );

  wide_router_resp i_resp (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( clear_i       ),
    .lane0_gnt_i   ( lane0_gnt     ),
    .offset_i      ( offset        ),
    .bank_rvalid_i ( bank_rvalid_i ),
    .bank_rdata_i  ( bank_rdata_i  ),
    .wide_rvalid_o ( wide_rvalid_o ),
    .wide_rdata_o  ( wide_rdata_o  )
  );

endmodule

// ==== verif/tb_bank_model.sv ====
// Behavioral model of the eight memory banks behind the wide router.
// Grants every request unless stall_i is high and answers one cycle later.
// The testbench reads the memories through the hierarchy to check placement.

`include "wide_router_cfg.svh"

module tb_bank_model (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           stall_i,
  input  logic [`WR_NB_BANKS-1:0]                        bank_req_i,
  input  logic                                           bank_wen_i,
  input  wide_router_pkg::bank_addr_t [`WR_NB_BANKS-1:0] bank_add_i,
  input  wide_router_pkg::lane_be_t [`WR_NB_BANKS-1:0]   bank_be_i,
  input  wide_router_pkg::lane_data_t [`WR_NB_BANKS-1:0] bank_wdata_i,
  output logic [`WR_NB_BANKS-1:0]                        bank_gnt_o,
  output logic [`WR_NB_BANKS-1:0]                        bank_rvalid_o,
  output wide_router_pkg::lane_data_t [`WR_NB_BANKS-1:0] bank_rdata_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // one array of rows per bank
  wide_router_pkg::lane_data_t mem [`WR_NB_BANKS][1 << `WR_BANK_AW];

  // fill pattern mixes bank and row so a misrouted access shows up
  initial begin
    for (int b = 0; b < `WR_NB_BANKS; b++) begin
      for (int r = 0; r < (1 << `WR_BANK_AW); r++) begin
        mem[b][r] = {8'(b), 8'(r), 8'(b) ^ 8'(r), ~8'(r)};
      end
    end
  end

  // a stall holds off all banks at once
  assign bank_gnt_o = bank_req_i & {`WR_NB_BANKS{~stall_i}};

  // one cycle latency for reads and writes alike
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bank_rvalid_o <= '0;
      bank_rdata_o  <= '0;
    end else begin
      for (int b = 0; b < `WR_NB_BANKS; b++) begin
        bank_rvalid_o[b] <= bank_gnt_o[b];
        if (bank_gnt_o[b]) begin
          bank_rdata_o[b] <= mem[b][bank_add_i[b]];
          // wen low means write, bytes merge under the enables
          if (!bank_wen_i) begin
            for (int k = 0; k < `WR_LANE_DW / 8; k++) begin
              if (bank_be_i[b][k]) begin
                mem[b][bank_add_i[b]][8*k +: 8] <= bank_wdata_i[b][8*k +: 8];
              end
            end
          end
        end
      end
    end
  end

endmodule

// ==== verif/tb_wide_router.sv ====
// Directed testbench of the wide router with a behavioral bank array.
// Each test drives wide transfers and checks routing, bank memory and read data
// against a lane-to-bank reference mapping kept here.

`include "wide_router_cfg.svh"

module tb_wide_router;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned GNT_TIMEOUT = 50;
  localparam int unsigned RSP_TIMEOUT = 4;
  localparam int unsigned LANE_BW     = `WR_LANE_DW / 8;

  logic                                           clk_i;
  logic                                           rst_ni;
  logic                                           clear;
  logic                                           wide_req;
  logic                                           wide_wen;
  wide_router_pkg::wide_addr_t                    wide_add;
  wide_router_pkg::wide_be_t                      wide_be;
  wide_router_pkg::wide_data_t                    wide_wdata;
  logic                                           wide_gnt;
  logic                                           wide_rvalid;
  wide_router_pkg::wide_data_t                    wide_rdata;
  logic [`WR_NB_BANKS-1:0]                        bank_req;
  logic                                           bank_wen;
  wide_router_pkg::bank_addr_t [`WR_NB_BANKS-1:0] bank_add;
  wide_router_pkg::lane_be_t [`WR_NB_BANKS-1:0]   bank_be;
  wide_router_pkg::lane_data_t [`WR_NB_BANKS-1:0] bank_wdata;
  logic [`WR_NB_BANKS-1:0]                        bank_gnt;
  logic [`WR_NB_BANKS-1:0]                        bank_rvalid;
  wide_router_pkg::lane_data_t [`WR_NB_BANKS-1:0] bank_rdata;
  logic                                           stall;
  logic                                           stall_en;

  // expected bank contents
  wide_router_pkg::lane_data_t ref_mem [`WR_NB_BANKS][1 << `WR_BANK_AW];
  logic [15:0] lfsr;
  int unsigned errors, checks, tests, test_err_start, stall_cycles;

  wide_router_top uut (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .clear_i       ( clear       ),
    .wide_req_i    ( wide_req    ),
    .wide_wen_i    ( wide_wen    ),
    .wide_add_i    ( wide_add    ),
    .wide_be_i     ( wide_be     ),
    .wide_wdata_i  ( wide_wdata  ),
    .wide_gnt_o    ( wide_gnt    ),
    .wide_rvalid_o ( wide_rvalid ),
    .wide_rdata_o  ( wide_rdata  ),
    .bank_req_o    ( bank_req    ),
    .bank_wen_o    ( bank_wen    ),
    .bank_add_o    ( bank_add    ),
    .bank_be_o     ( bank_be     ),
    .bank_wdata_o  ( bank_wdata  ),
    .bank_gnt_i    ( bank_gnt    ),
    .bank_rvalid_i ( bank_rvalid ),
    .bank_rdata_i  ( bank_rdata  )
  );

  tb_bank_model i_bank_model (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .stall_i       ( stall       ),
    .bank_req_i    ( bank_req    ),
    .bank_wen_i    ( bank_wen    ),
    .bank_add_i    ( bank_add    ),
    .bank_be_i     ( bank_be     ),
    .bank_wdata_i  ( bank_wdata  ),
    .bank_gnt_o    ( bank_gnt    ),
    .bank_rvalid_o ( bank_rvalid ),
    .bank_rdata_o  ( bank_rdata  )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // galois form with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic wide_router_pkg::wide_addr_t make_addr(input logic [7:0] row,
                                                            input logic [2:0] off);
    return {row, off, 2'b00};
  endfunction

  // lane l goes to bank (offset + l) mod 8
  function automatic wide_router_pkg::bank_sel_t ref_bank(input wide_router_pkg::wide_addr_t a,
                                                          input int l);
    return wide_router_pkg::bank_sel_t'((int'(a[4:2]) + l) % `WR_NB_BANKS);
  endfunction

  // and one row further once it wraps past bank 7
  function automatic wide_router_pkg::bank_addr_t ref_row(input wide_router_pkg::wide_addr_t a,
                                                          input int l);
    return (int'(a[4:2]) + l >= `WR_NB_BANKS) ? a[12:5] + 8'd1 : a[12:5];
  endfunction

  function automatic wide_router_pkg::wide_data_t exp_read(input wide_router_pkg::wide_addr_t a);
    wide_router_pkg::wide_data_t d;
    for (int l = 0; l < `WR_NB_LANES; l++) begin
      d[l*`WR_LANE_DW +: `WR_LANE_DW] = ref_mem[ref_bank(a, l)][ref_row(a, l)];
    end
    return d;
  endfunction

  task automatic ref_write(input wide_router_pkg::wide_addr_t a, input wide_router_pkg::wide_be_t be,
                           input wide_router_pkg::wide_data_t wd);
    for (int l = 0; l < `WR_NB_LANES; l++) begin
      for (int k = 0; k < LANE_BW; k++) begin
        if (be[l*LANE_BW + k]) begin
          ref_mem[ref_bank(a, l)][ref_row(a, l)][8*k +: 8] = wd[l*`WR_LANE_DW + 8*k +: 8];
        end
      end
    end
  endtask

  task automatic check_value(input string what, input logic [255:0] got, input logic [255:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s mismatch, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s at %0t ns", msg, $time);
    $display("Test FAILED");
    $finish;
  endtask

  // one lfsr step per stall bit and no stall unless enabled
  task automatic draw_stall();
    if (stall_en) begin
      lfsr = lfsr_step(lfsr);
      stall = lfsr[0];
      if (stall) stall_cycles++;
    end else begin
      stall = 1'b0;
    end
  endtask

  task automatic begin_test();
    test_err_start = errors;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("%s: %s, %0d errors", name, (errors == test_err_start) ? "pass" : "fail",
             errors - test_err_start);
  endtask

  // bank side of a pending request against the reference mapping
  task automatic check_routing(input logic wen, input wide_router_pkg::wide_addr_t a,
                               input wide_router_pkg::wide_be_t be,
                               input wide_router_pkg::wide_data_t wd);
    logic [`WR_NB_BANKS-1:0]    exp_req;
    wide_router_pkg::bank_sel_t b;
    exp_req = '0;
    for (int l = 0; l < `WR_NB_LANES; l++) begin
      b = ref_bank(a, l);
      exp_req[b] = 1'b1;
      check_value("bank row", bank_add[b], ref_row(a, l));
      if (!wen) begin
        check_value("bank wdata", bank_wdata[b], wd[l*`WR_LANE_DW +: `WR_LANE_DW]);
        check_value("bank byte enable", bank_be[b], be[l*LANE_BW +: LANE_BW]);
      end
    end
    check_value("bank requests", bank_req, exp_req);
    check_value("bank wen", bank_wen, wen);
  endtask

  // written lanes must sit in the bank and row of the reference mapping
  task automatic check_placement(input wide_router_pkg::wide_addr_t a,
                                 input wide_router_pkg::wide_data_t wd);
    for (int l = 0; l < `WR_NB_LANES; l++) begin
      check_value("lane placement", i_bank_model.mem[ref_bank(a, l)][ref_row(a, l)],
                  wd[l*`WR_LANE_DW +: `WR_LANE_DW]);
    end
  endtask

  // one wide transfer that holds the request through any stall
  task automatic wide_access(input logic wen, input wide_router_pkg::wide_addr_t a,
                             input wide_router_pkg::wide_be_t be,
                             input wide_router_pkg::wide_data_t wd,
                             output wide_router_pkg::wide_data_t rd);
    int unsigned                                    waited;
    logic [`WR_NB_BANKS-1:0]                        req_snap;
    wide_router_pkg::bank_addr_t [`WR_NB_BANKS-1:0] add_snap;
    wide_router_pkg::lane_data_t [`WR_NB_BANKS-1:0] data_snap;
    wide_router_pkg::lane_be_t [`WR_NB_BANKS-1:0]   be_snap;
    @(posedge clk_i);
    #10;
    wide_req   = 1'b1;
    wide_wen   = wen;
    wide_add   = a;
    wide_be    = be;
    wide_wdata = wd;
    draw_stall();
    waited = 0;
    @(negedge clk_i);
    check_routing(wen, a, be, wd);
    req_snap  = bank_req;
    add_snap  = bank_add;
    data_snap = bank_wdata;
    be_snap   = bank_be;
    while (!wide_gnt) begin
      check_value("r_valid while stalled", wide_rvalid, 1'b0);
      if (waited >= GNT_TIMEOUT) abort_run("timeout waiting for the wide grant");
      @(posedge clk_i);
      #10;
      draw_stall();
      @(negedge clk_i);
      waited++;
      // payload must not move while the banks stall
      check_value("bank_req under stall", bank_req, req_snap);
      check_value("bank_add under stall", bank_add, add_snap);
      check_value("bank_wdata under stall", bank_wdata, data_snap);
      check_value("bank_be under stall", bank_be, be_snap);
    end
    // banks take the word at the coming edge
    if (!wen) ref_write(a, be, wd);
    @(posedge clk_i);
    #10;
    wide_req = 1'b0;
    stall    = 1'b0;
    waited   = 0;
    @(negedge clk_i);
    while (!wide_rvalid) begin
      if (waited >= RSP_TIMEOUT) abort_run("timeout waiting for the wide r_valid");
      @(negedge clk_i);
      waited++;
    end
    check_value("r_valid latency", waited, 0);
    rd = wide_rdata;
    if (wen) begin
      check_value("read data", rd, exp_read(a));
    end else begin
      for (int l = 0; l < `WR_NB_LANES; l++) begin
        check_value("bank memory", i_bank_model.mem[ref_bank(a, l)][ref_row(a, l)],
                    ref_mem[ref_bank(a, l)][ref_row(a, l)]);
      end
    end
    // exactly one response per transfer
    @(negedge clk_i);
    check_value("extra r_valid", wide_rvalid, 1'b0);
  endtask

  // write then read one full word and check its placement in the banks
  task automatic test_full_word(input string name, input wide_router_pkg::wide_addr_t a,
                                input wide_router_pkg::wide_data_t wd);
    wide_router_pkg::wide_data_t rd;
    begin_test();
    wide_access(1'b0, a, '1, wd, rd);
    check_placement(a, wd);
    wide_access(1'b1, a, '0, '0, rd);
    check_value("read back", rd, wd);
    end_test(name);
  endtask

  task automatic test_partial_be();
    wide_router_pkg::wide_addr_t a;
    wide_router_pkg::wide_data_t rd;
    begin_test();
    a = make_addr(8'd9, 3'd5);
    wide_access(1'b0, a, '1, 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210, rd);
    // only enabled bytes merge in
    wide_access(1'b0, a, 16'ha5c3, 128'hdead_beef_cafe_f00d_1111_2222_3333_4444, rd);
    wide_access(1'b1, a, '0, '0, rd);
    end_test("partial byte enables");
  endtask

  task automatic test_backpressure();
    wide_router_pkg::wide_addr_t a;
    wide_router_pkg::wide_data_t wd;
    wide_router_pkg::wide_data_t rd;
    begin_test();
    stall_en     = 1'b1;
    stall_cycles = 0;
    for (int k = 0; k < 6; k++) begin
      a  = make_addr(8'(60 + k), 3'(3 * k));
      wd = {4{32'h5a00_0000 + 32'(k)}} ^ 128'h1000_0000_2000_0000_3000_0000_4000_0000;
      wide_access(1'b0, a, '1, wd, rd);
      wide_access(1'b1, a, '0, '0, rd);
      check_value("stalled read back", rd, wd);
    end
    stall_en = 1'b0;
    if (stall_cycles == 0) begin
      errors++;
      $display("back-pressure test never stalled the banks");
    end
    end_test("back-pressure");
  endtask

  task automatic test_back_to_back();
    wide_router_pkg::wide_addr_t addrs [4];
    wide_router_pkg::wide_data_t rd;
    int unsigned                 waited;
    begin_test();
    // distinct lanes so a late or early offset shows up in the rotation
    for (int k = 0; k < 4; k++) begin
      addrs[k] = make_addr(8'(100 + 7 * k), 3'(2 * k + 1));
      wide_access(1'b0, addrs[k], '1,
                  {32'hc0de_0300, 32'hc0de_0200, 32'hc0de_0100, 32'hc0de_0000} |
                  {4{32'(k)}}, rd);
    end
    @(posedge clk_i);
    #10;
    for (int k = 0; k < 4; k++) begin
      wide_req = 1'b1;
      wide_wen = 1'b1;
      wide_add = addrs[k];
      wide_be  = '0;
      waited   = 0;
      @(negedge clk_i);
      // response of the previous read overlaps this request
      if (k > 0) begin
        check_value("back-to-back r_valid", wide_rvalid, 1'b1);
        check_value("back-to-back data", wide_rdata, exp_read(addrs[k-1]));
      end
      while (!wide_gnt) begin
        if (waited >= GNT_TIMEOUT) abort_run("timeout waiting for a back-to-back grant");
        @(negedge clk_i);
        waited++;
      end
      check_value("back-to-back grant delay", waited, 0);
      @(posedge clk_i);
      #10;
    end
    wide_req = 1'b0;
    @(negedge clk_i);
    check_value("last r_valid", wide_rvalid, 1'b1);
    check_value("last data", wide_rdata, exp_read(addrs[3]));
    // clear while idle must not produce an r_valid
    @(posedge clk_i);
    #10;
    clear = 1'b1;
    for (int c = 0; c < 3; c++) begin
      @(negedge clk_i);
      check_value("r_valid during clear", wide_rvalid, 1'b0);
    end
    @(posedge clk_i);
    #10;
    clear = 1'b0;
    wide_access(1'b1, addrs[0], '0, '0, rd);
    end_test("back-to-back reads and clear");
  endtask

  initial begin
    rst_ni       = 1'b0;
    clear        = 1'b0;
    wide_req     = 1'b0;
    wide_wen     = 1'b0;
    wide_add     = '0;
    wide_be      = '0;
    wide_wdata   = '0;
    stall        = 1'b0;
    stall_en     = 1'b0;
    lfsr         = 16'd16586;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    stall_cycles = 0;
    repeat (8) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    // start the reference from the initial bank contents
    for (int b = 0; b < `WR_NB_BANKS; b++) begin
      for (int r = 0; r < (1 << `WR_BANK_AW); r++) begin
        ref_mem[b][r] = i_bank_model.mem[b][r];
      end
    end
    test_full_word("aligned write/read", make_addr(8'd5, 3'd0),
                   128'h3333_3333_2222_2222_1111_1111_0000_0000);
    test_full_word("unaligned offset", make_addr(8'd17, 3'd3),
                   128'hdddd_0003_cccc_0002_bbbb_0001_aaaa_0000);
    test_full_word("wraparound", make_addr(8'd40, 3'd6),
                   128'h4444_aaaa_3333_bbbb_2222_cccc_1111_dddd);
    test_partial_be();
    test_backpressure();
    test_back_to_back();
    $display("%0d tests run, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== wide_router/wide_router_decode.sv ====
// Address decode of the wide router.
// Splits the wide byte address into bank offset and row, and gives every
// lane its target bank, its row and its active flag. Purely combinational.

`include "wide_router_cfg.svh"

module wide_router_decode (
  input  logic                                         wide_req_i,
  input  wide_router_pkg::wide_addr_t                  wide_add_i,
  output wide_router_pkg::bank_sel_t [`WR_NB_LANES-1:0] lane_bank_o,
  output wide_router_pkg::bank_addr_t [`WR_NB_LANES-1:0] lane_add_o,
  output logic [`WR_NB_LANES-1:0]                      lane_act_o,
  output wide_router_pkg::bank_sel_t                   offset_o
);

  // shared row of the wide word, before any wrap
  wide_router_pkg::bank_addr_t row;

  // byte offset in bits 1:0 is dropped
  // bank offset sits right above it
  assign offset_o = wide_add_i[`WR_BANK_SW+1:2];

  // row takes everything above the bank select
  assign row = wide_add_i[`WR_WIDE_AW-1:`WR_BANK_SW+2];

  for (genvar l = 0; l < `WR_NB_LANES; l++) begin : gen_lane

    // one extra bit catches the wrap past the last bank
    logic [`WR_BANK_SW:0] lane_sum;
    logic                 lane_wrap;

    // bank of lane l is (offset + l) mod bank count
    assign lane_sum  = {1'b0, offset_o} + (`WR_BANK_SW+1)'(l);
    assign lane_wrap = lane_sum[`WR_BANK_SW];

    // dropping the carry gives the modulo, banks being a power of two
    assign lane_bank_o[l] = lane_sum[`WR_BANK_SW-1:0];

    // a wrapped lane has moved into the next row of the interleave
    assign lane_add_o[l] = row + wide_router_pkg::bank_addr_t'(lane_wrap);

    // every lane of the wide word goes out with the request
    // there is no partial-lane request on this port
    assign lane_act_o[l] = wide_req_i;

  end

endmodule

// ==== wide_router/wide_router_reorder.sv ====
// Lane-to-bank rotation of the wide router.
// Places each active lane on the bank that decode picked for it and
// returns the wide grant from the bank that serves lane 0.

`include "wide_router_cfg.svh"

module wide_router_reorder (
  // clock and reset only sample the protocol checks
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  wide_router_pkg::bank_sel_t [`WR_NB_LANES-1:0]  lane_bank_i,
  input  wide_router_pkg::bank_addr_t [`WR_NB_LANES-1:0] lane_add_i,
  input  logic [`WR_NB_LANES-1:0]                        lane_act_i,
  input  logic                                           wide_wen_i,
  input  wide_router_pkg::wide_be_t                      wide_be_i,
  input  wide_router_pkg::wide_data_t                    wide_wdata_i,
  input  logic [`WR_NB_BANKS-1:0]                        bank_gnt_i,
  output logic [`WR_NB_BANKS-1:0]                        bank_req_o,
  output logic                                           bank_wen_o,
  output wide_router_pkg::bank_addr_t [`WR_NB_BANKS-1:0] bank_add_o,
  output wide_router_pkg::lane_be_t [`WR_NB_BANKS-1:0]   bank_be_o,
  output wide_router_pkg::lane_data_t [`WR_NB_BANKS-1:0] bank_wdata_o,
  output logic                                           lane0_gnt_o,
  output logic                                           wide_gnt_o
);

  localparam int unsigned LANE_BW = `WR_LANE_DW / 8;

  // high when two active lanes point at one bank
  logic lane_clash;

  // read or write is common to the whole wide word
  assign bank_wen_o = wide_wen_i;

  // each bank looks for the active lane that targets it
  // banks nobody targets stay idle with a zero payload
  always_comb begin
    bank_req_o   = '0;
    bank_add_o   = '0;
    bank_be_o    = '0;
    bank_wdata_o = '0;
    for (int b = 0; b < `WR_NB_BANKS; b++) begin
      for (int l = 0; l < `WR_NB_LANES; l++) begin
        if (lane_act_i[l] && lane_bank_i[l] == wide_router_pkg::bank_sel_t'(b)) begin
          bank_req_o[b]   = 1'b1;
          bank_add_o[b]   = lane_add_i[l];
          bank_be_o[b]    = wide_be_i[l*LANE_BW +: LANE_BW];
          bank_wdata_o[b] = wide_wdata_i[l*`WR_LANE_DW +: `WR_LANE_DW];
        end
      end
    end
  end

  // lane 0's bank speaks for all banks of the word
  // only a requesting lane may see a grant
  assign lane0_gnt_o = bank_gnt_i[lane_bank_i[0]] & lane_act_i[0];
  assign wide_gnt_o  = lane0_gnt_o;

  // pairwise search for a bank hit by two lanes
  always_comb begin
    lane_clash = 1'b0;
    for (int a = 0; a < `WR_NB_LANES; a++) begin
      for (int c = a + 1; c < `WR_NB_LANES; c++) begin
        if (lane_act_i[a] && lane_act_i[c] && lane_bank_i[a] == lane_bank_i[c]) begin
          lane_clash = 1'b1;
        end
      end
    end
  end

  // a stall must hit every bank of the word at once, otherwise
  // following lane 0's grant would lose or repeat other lanes
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bank_req_o != '0) |->
      ((bank_gnt_i & bank_req_o) == '0 || (bank_gnt_i & bank_req_o) == bank_req_o))
    else $error("banks of one wide request granted apart");

  // decode has to spread the lanes over distinct banks
  assert property (@(posedge clk_i) disable iff (!rst_ni) !lane_clash)
    else $error("two lanes target the same bank");

endmodule

// ==== wide_router/wide_router_resp.sv ====
// Response path of the wide router.
// Remembers the transfer and its offset for one cycle, filters the bank
// r_valid with it and rotates the bank read data back into lane order.

`include "wide_router_cfg.svh"

module wide_router_resp (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           clear_i,
  input  logic                                           lane0_gnt_i,
  input  wide_router_pkg::bank_sel_t                     offset_i,
  input  logic [`WR_NB_BANKS-1:0]                        bank_rvalid_i,
  input  wide_router_pkg::lane_data_t [`WR_NB_BANKS-1:0] bank_rdata_i,
  output logic                                           wide_rvalid_o,
  output wide_router_pkg::wide_data_t                    wide_rdata_o
);

  // transfer seen in the previous cycle
  logic                       gnt_q;
  // bank that served lane 0 in that transfer
  wide_router_pkg::bank_sel_t offset_q;

  // the memory protocol puts r_valid exactly one cycle after the grant,
  // so one stage is enough to follow a single response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q    <= 1'b0;
      offset_q <= '0;
    end else if (clear_i) begin
      gnt_q    <= 1'b0;
      offset_q <= '0;
    end else begin
      gnt_q <= lane0_gnt_i;
      // keep the old offset while idle
      if (lane0_gnt_i) begin
        offset_q <= offset_i;
      end
    end
  end

  // lane 0's bank again stands for the whole word
  assign wide_rvalid_o = bank_rvalid_i[offset_q] & gnt_q;

  // lane l reads from bank (offset + l) mod bank count
  always_comb begin
    wide_rdata_o = '0;
    for (int l = 0; l < `WR_NB_LANES; l++) begin
      wide_rdata_o[l*`WR_LANE_DW +: `WR_LANE_DW] =
        bank_rdata_i[wide_router_pkg::bank_sel_t'(offset_q + l)];
    end
  end

  // banks only answer a transfer made through this router
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bank_rvalid_i != '0) |-> gnt_q)
    else $error("bank r_valid without a preceding wide grant");

endmodule
